/* include/load_unit_macros.svh */
//--------------------------------------
// load unit sizing
//--------------------------------------
`ifndef LOAD_UNIT_MACROS_SVH
`define LOAD_UNIT_MACROS_SVH

// data path width, one 64-bit word
`define LU_XLEN 64

// byte offset inside a word
`define LU_ALIGN_BITS 3

// outstanding-load buffer depth, two or more
`define LU_NR_ENTRIES 4

// cache request id, log2 of the buffer depth
`define LU_REQ_ID_BITS 2

// scoreboard transaction id
`define LU_TRANS_ID_BITS 3

// cache index and tag split of the address
`define LU_INDEX_BITS 12
`define LU_TAG_BITS 20

`endif

/* logic/load_pkg.sv */
//--------------------------------------
// load unit types
//--------------------------------------
`include "load_unit_macros.svh"

package load_pkg;

  //--------------------------------------
  // load type
  //--------------------------------------
  // word, signed and unsigned word, half and byte
  // the encoding only matters inside the unit
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } load_op_e;

  //--------------------------------------
  // outstanding-load buffer entry
  //--------------------------------------
  // everything the response side needs to retire a load
  // trans_id goes back to the scoreboard
  // offset and op drive the aligner
  typedef struct packed {
    // scoreboard id of the load
    logic [`LU_TRANS_ID_BITS-1:0] trans_id;
    // low address bits, byte position in the word
    logic [`LU_ALIGN_BITS-1:0]    offset;
    // load type for size and extension
    load_op_e                     op;
  } ldbuf_entry_t;

endpackage

/* logic/load_request_fsm.sv */
//--------------------------------------
// load request state machine
//--------------------------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_request_fsm (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  flush_i,
  // issue side
  input  logic                                  valid_i,
  input  logic [`LU_TAG_BITS+`LU_INDEX_BITS-1:0] vaddr_i,
  input  load_pkg::load_op_e                    op_i,
  // store check
  input  logic                                  page_offset_matches_i,
  // cache handshake
  input  logic                                  data_gnt_i,
  input  logic                                  buf_full_i,
  output logic                                  pop_o,
  output logic                                  alloc_o,
  output logic                                  data_req_o,
  output logic [`LU_INDEX_BITS-1:0]             address_index_o,
  output logic [`LU_TAG_BITS-1:0]               address_tag_o,
  output logic [1:0]                            data_size_o,
  output logic                                  tag_valid_o,
  output logic                                  kill_req_o
);
  import load_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_PAGE_OFFSET,
    WAIT_FLUSH
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  logic [`LU_TAG_BITS-1:0] tag_q;
  logic                    accept;

  // a new load only starts while a buffer slot is free
  assign accept = valid_i && !buf_full_i;

  // index goes out with the request, straight from the address
  assign address_index_o = vaddr_i[`LU_INDEX_BITS-1:0];

  // granted request, the buffer takes an entry
  assign alloc_o = data_req_o && data_gnt_i;

  // log2 of the access bytes
  always_comb begin
    case (op_i)
      LW, LWU: data_size_o = 2'd2;
      LH, LHU: data_size_o = 2'd1;
      LB, LBU: data_size_o = 2'd0;
      default: data_size_o = 2'd3;
    endcase
  end

  //--------------------------------------
  // request control
  //--------------------------------------
  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    pop_o       = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;

    case (state_q)
      // send tag shares the accept path with idle
      // so loads can go back to back
      IDLE, SEND_TAG: begin
        tag_valid_o = (state_q == SEND_TAG);
        state_d     = IDLE;
        if (accept) begin
          if (page_offset_matches_i) begin
            // a pending store overlaps, hold off
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            if (data_gnt_i) begin
              pop_o   = 1'b1;
              state_d = SEND_TAG;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      // request stays up until the cache grants it
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_o   = 1'b1;
          state_d = SEND_TAG;
        end
      end

      // retry once the store no longer overlaps
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end

      // cancel whatever tag the cache still waits for
      WAIT_FLUSH: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end

      default: state_d = IDLE;
    endcase

    // flush wins over any other transition
    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag bits kept for the cycle after the grant
  always_ff @(posedge clk_i) begin
    if (alloc_o) begin
      tag_q <= vaddr_i[`LU_TAG_BITS+`LU_INDEX_BITS-1:`LU_INDEX_BITS];
    end
  end

  assign address_tag_o = tag_q;

endmodule

/* logic/load_buffer.sv */
//--------------------------------------
// outstanding-load buffer
//--------------------------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_buffer (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  // write side, from the request FSM
  input  logic                         alloc_i,
  input  logic [`LU_TRANS_ID_BITS-1:0] trans_id_i,
  input  logic [`LU_ALIGN_BITS-1:0]    offset_i,
  input  load_pkg::load_op_e           op_i,
  input  logic                         kill_req_i,
  // read side, from the cache response
  input  logic                         data_rvalid_i,
  input  logic [`LU_REQ_ID_BITS-1:0]   data_rid_i,
  output logic                         full_o,
  output logic [`LU_REQ_ID_BITS-1:0]   free_id_o,
  output logic                         rd_valid_o,
  output load_pkg::ldbuf_entry_t       rd_entry_o
);
  import load_pkg::*;

  ldbuf_entry_t                entries_q [`LU_NR_ENTRIES];
  logic [`LU_NR_ENTRIES-1:0]   valid_q;
  logic [`LU_NR_ENTRIES-1:0]   valid_d;
  logic [`LU_NR_ENTRIES-1:0]   flushed_q;
  logic [`LU_NR_ENTRIES-1:0]   flushed_d;
  logic [`LU_REQ_ID_BITS-1:0]  last_id_q;

  assign full_o = &valid_q;

  // lowest free slot, scan from the top so the last hit wins
  always_comb begin
    free_id_o = '0;
    for (int i = `LU_NR_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id_o = i[`LU_REQ_ID_BITS-1:0];
      end
    end
  end

  //--------------------------------------
  // slot flags
  //--------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // flush silences every outstanding load
    if (flush_i) begin
      flushed_d = '1;
    end
    // response frees its slot, it cannot be stalled
    if (data_rvalid_i) begin
      valid_d[data_rid_i] = 1'b0;
    end
    // a new load takes the free slot, clean
    if (alloc_i) begin
      valid_d[free_id_o]   = 1'b1;
      flushed_d[free_id_o] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      // id of the most recent request, the one a kill can hit
      if (alloc_i) begin
        last_id_q <= free_id_o;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      entries_q[free_id_o] <= '{trans_id: trans_id_i, offset: offset_i, op: op_i};
    end
  end

  //--------------------------------------
  // response lookup
  //--------------------------------------
  assign rd_entry_o = entries_q[data_rid_i];

  // drop responses for flushed slots and for the request being killed
  assign rd_valid_o = data_rvalid_i && valid_q[data_rid_i] && !flushed_q[data_rid_i] &&
                      !(kill_req_i && (data_rid_i == last_id_q));

endmodule

/* logic/load_align.sv */
//--------------------------------------
// load result aligner
//--------------------------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_align (
  input  logic                         rd_valid_i,
  input  load_pkg::ldbuf_entry_t       rd_entry_i,
  input  logic [`LU_XLEN-1:0]          data_rdata_i,
  output logic                         valid_o,
  output logic [`LU_TRANS_ID_BITS-1:0] trans_id_o,
  output logic [`LU_XLEN-1:0]          result_o
);
  import load_pkg::*;

  logic [`LU_XLEN-1:0]       shifted;
  logic [`LU_XLEN/8-1:0]     byte_msbs;
  logic [`LU_ALIGN_BITS-1:0] sign_byte;
  logic                      is_signed;
  logic                      sign_bit;

  assign valid_o    = rd_valid_i;
  assign trans_id_o = rd_entry_i.trans_id;

  // move the addressed bytes down to bit 0
  assign shifted = data_rdata_i >> {rd_entry_i.offset, 3'b000};

  // top bit of every byte, the sign is picked from here
  // in parallel with the shifter
  for (genvar i = 0; i < `LU_XLEN / 8; i++) begin : gen_byte_msbs
    assign byte_msbs[i] = data_rdata_i[8*i+7];
  end

  // top byte of the access
  always_comb begin
    case (rd_entry_i.op)
      LW:      sign_byte = rd_entry_i.offset + 3'd3;
      LH:      sign_byte = rd_entry_i.offset + 3'd1;
      default: sign_byte = rd_entry_i.offset;
    endcase
  end

  assign is_signed = rd_entry_i.op inside {LW, LH, LB};
  // unsigned loads extend with zero
  assign sign_bit  = is_signed && byte_msbs[sign_byte];

  //--------------------------------------
  // extension
  //--------------------------------------
  always_comb begin
    case (rd_entry_i.op)
      LW, LWU: result_o = {{(`LU_XLEN-32){sign_bit}}, shifted[31:0]};
      LH, LHU: result_o = {{(`LU_XLEN-16){sign_bit}}, shifted[15:0]};
      LB, LBU: result_o = {{(`LU_XLEN-8){sign_bit}}, shifted[7:0]};
      // full word, nothing to extend
      default: result_o = shifted;
    endcase
  end

endmodule

/* logic/load_unit_top.sv */
//--------------------------------------
// load unit top
//--------------------------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_unit_top (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  flush_i,
  // issue side
  input  logic                                  valid_i,
  input  logic [`LU_TRANS_ID_BITS-1:0]          trans_id_i,
  input  logic [`LU_TAG_BITS+`LU_INDEX_BITS-1:0] vaddr_i,
  input  load_pkg::load_op_e                    op_i,
  output logic                                  pop_o,
  // store check
  output logic [`LU_INDEX_BITS-1:0]             page_offset_o,
  input  logic                                  page_offset_matches_i,
  // cache request and tag
  output logic                                  data_req_o,
  output logic [`LU_INDEX_BITS-1:0]             address_index_o,
  output logic [`LU_REQ_ID_BITS-1:0]            data_id_o,
  output logic [1:0]                            data_size_o,
  input  logic                                  data_gnt_i,
  output logic                                  tag_valid_o,
  output logic [`LU_TAG_BITS-1:0]               address_tag_o,
  output logic                                  kill_req_o,
  // cache response
  input  logic                                  data_rvalid_i,
  input  logic [`LU_REQ_ID_BITS-1:0]            data_rid_i,
  input  logic [`LU_XLEN-1:0]                   data_rdata_i,
  // writeback
  output logic                                  valid_o,
  output logic [`LU_TRANS_ID_BITS-1:0]          trans_id_o,
  output logic [`LU_XLEN-1:0]                   result_o
);
  import load_pkg::*;

  logic                       alloc;
  logic                       buf_full;
  logic [`LU_REQ_ID_BITS-1:0] free_id;
  logic                       rd_valid;
  ldbuf_entry_t               rd_entry;

  // low address bits go to the store check
  assign page_offset_o = vaddr_i[`LU_INDEX_BITS-1:0];
  // request id is the slot the load will occupy
  assign data_id_o     = free_id;

  // producer, drives the cache request side
  load_request_fsm u_fsm (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .vaddr_i               (vaddr_i),
    .op_i                  (op_i),
    .page_offset_matches_i (page_offset_matches_i),
    .data_gnt_i            (data_gnt_i),
    .buf_full_i            (buf_full),
    .pop_o                 (pop_o),
    .alloc_o               (alloc),
    .data_req_o            (data_req_o),
    .address_index_o       (address_index_o),
    .address_tag_o         (address_tag_o),
    .data_size_o           (data_size_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o)
  );

  // tracks loads between grant and response
  load_buffer u_buffer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .alloc_i       (alloc),
    .trans_id_i    (trans_id_i),
    .offset_i      (vaddr_i[`LU_ALIGN_BITS-1:0]),
    .op_i          (op_i),
    .kill_req_i    (kill_req_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rid_i    (data_rid_i),
    .full_o        (buf_full),
    .free_id_o     (free_id),
    .rd_valid_o    (rd_valid),
    .rd_entry_o    (rd_entry)
  );

  // consumer, same-cycle result
  load_align u_align (
    .rd_valid_i   (rd_valid),
    .rd_entry_i   (rd_entry),
    .data_rdata_i (data_rdata_i),
    .valid_o      (valid_o),
    .trans_id_o   (trans_id_o),
    .result_o     (result_o)
  );

endmodule

/* bench/load_unit_tb.sv */
//--------------------------------------
// load unit testbench
//--------------------------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_unit_tb;
  import load_pkg::*;

  localparam int clk_period      = 20;
  localparam int reset_cycles    = 16;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 200;

  logic                                   clk_i;
  logic                                   rst_n_i;
  logic                                   flush_i;
  logic                                   valid_i;
  logic [`LU_TRANS_ID_BITS-1:0]           trans_id_i;
  logic [`LU_TAG_BITS+`LU_INDEX_BITS-1:0] vaddr_i;
  load_op_e                               op_i;
  logic                                   pop_o;
  logic [`LU_INDEX_BITS-1:0]              page_offset_o;
  logic                                   page_offset_matches_i;
  logic                                   data_req_o;
  logic [`LU_INDEX_BITS-1:0]              address_index_o;
  logic [`LU_REQ_ID_BITS-1:0]             data_id_o;
  logic [1:0]                             data_size_o;
  logic                                   data_gnt_i;
  logic                                   tag_valid_o;
  logic [`LU_TAG_BITS-1:0]                address_tag_o;
  logic                                   kill_req_o;
  logic                                   data_rvalid_i;
  logic [`LU_REQ_ID_BITS-1:0]             data_rid_i;
  logic [`LU_XLEN-1:0]                    data_rdata_i;
  logic                                   valid_o;
  logic [`LU_TRANS_ID_BITS-1:0]           trans_id_o;
  logic [`LU_XLEN-1:0]                    result_o;

  integer   seed = 73;
  int       error_count = 0;
  int       check_count = 0;
  int       tests_run = 0;
  load_op_e op_list [7] = '{LD, LW, LWU, LH, LHU, LB, LBU};

  load_unit_top dut (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  //--------------------------------------
  // reference model and helpers
  //--------------------------------------
  function automatic int size_log2(input load_op_e op);
    case (op)
      LD:      return 3;
      LW, LWU: return 2;
      LH, LHU: return 1;
      default: return 0;
    endcase
  endfunction

  function automatic int access_bytes(input load_op_e op);
    return 1 << size_log2(op);
  endfunction

  // pick the accessed bytes one by one and fill from the top byte's msb
  function automatic logic [63:0] expected_load(input logic [63:0] data, input logic [2:0] off,
                                                input load_op_e op);
    logic [63:0] v;
    int          nbytes;
    logic        signed_op;
    nbytes    = access_bytes(op);
    signed_op = (op == LW) || (op == LH) || (op == LB);
    v         = '0;
    for (int b = 0; b < nbytes; b++) begin
      v[8*b +: 8] = data[8*(off+b) +: 8];
    end
    if (signed_op && v[8*nbytes-1]) begin
      for (int b = nbytes; b < 8; b++) begin
        v[8*b +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  // grant delay of the cache model in cycles (0 to 2)
  function automatic int rand_delay();
    return int'($unsigned($random(seed)) % 3);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("error in %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string name, input string msg);
    error_count++;
    $display("test %s: %s", name, msg);
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests_run++;
    $display("test %s done, %0d errors", name, error_count - start_errors);
  endtask

  //--------------------------------------
  // cache model
  //--------------------------------------
  // holds the load until pop and grants after gnt_delay requesting cycles
  // the tag cycle is checked last
  // runs from just after one rising edge to just after another
  task automatic issue_load(input string name, input logic [2:0] tid, input logic [31:0] addr,
                            input load_op_e op, input int gnt_delay, output logic [1:0] rid);
    int   hold;
    int   waited;
    logic popped;
    logic req_seen;
    hold       = gnt_delay;
    waited     = 0;
    popped     = 1'b0;
    req_seen   = 1'b0;
    rid        = '0;
    valid_i    = 1'b1;
    trans_id_i = tid;
    vaddr_i    = addr;
    op_i       = op;
    data_gnt_i = (hold <= 0);
    while (!popped && waited < 20) begin
      @(negedge clk_i);
      // the request stays up from the first raise until the grant
      if (req_seen || data_req_o) begin
        check_value(name, 64'd1, 64'(data_req_o));
      end
      req_seen = req_seen || data_req_o;
      if (!data_gnt_i) begin
        check_value(name, 64'd0, 64'(pop_o));
      end
      if (pop_o) begin
        popped = 1'b1;
        rid    = data_id_o;
        check_value(name, 64'(addr[11:0]), 64'(address_index_o));
        check_value(name, 64'(size_log2(op)), 64'(data_size_o));
      end else begin
        check_value(name, 64'd0, 64'(tag_valid_o));
        if (data_req_o) begin
          hold--;
        end
      end
      @(posedge clk_i);
      #1;
      data_gnt_i = !popped && (hold <= 0);
      waited++;
    end
    valid_i    = 1'b0;
    data_gnt_i = 1'b0;
    if (!popped) begin
      report_failure(name, "the load was never popped by the unit");
    end else begin
      // tag follows the grant by one cycle
      @(negedge clk_i);
      check_value(name, 64'd1, 64'(tag_valid_o));
      check_value(name, 64'(addr[31:12]), 64'(address_tag_o));
      check_value(name, 64'd0, 64'(kill_req_o));
      @(posedge clk_i);
      #1;
    end
  endtask

  // one response cycle with a combinational result
  task automatic respond(input string name, input logic [1:0] rid, input logic [63:0] data,
                         input logic expect_valid, input logic [2:0] tid,
                         input logic [63:0] expected);
    data_rvalid_i = 1'b1;
    data_rid_i    = rid;
    data_rdata_i  = data;
    @(negedge clk_i);
    check_value(name, 64'(expect_valid), 64'(valid_o));
    if (expect_valid) begin
      check_value(name, 64'(tid), 64'(trans_id_o));
      check_value(name, expected, result_o);
    end
    @(posedge clk_i);
    #1;
    data_rvalid_i = 1'b0;
  endtask

  //--------------------------------------
  // directed tests
  //--------------------------------------
  task automatic all_load_types();
    string       name = "all_load_types";
    int          start_errors;
    int          count;
    logic [31:0] addr;
    logic [63:0] data;
    logic [1:0]  rid;
    start_errors = error_count;
    count        = 0;
    foreach (op_list[k]) begin
      for (int off = 0; off < 8; off += access_bytes(op_list[k])) begin
        addr      = $random(seed);
        addr[2:0] = off[2:0];
        data      = {$random(seed), $random(seed)};
        issue_load(name, 3'(count), addr, op_list[k], rand_delay(), rid);
        respond(name, rid, data, 1'b1, 3'(count), expected_load(data, off[2:0], op_list[k]));
        count++;
      end
    end
    end_test(name, start_errors);
  endtask

  task automatic reverse_responses();
    string       name = "reverse_responses";
    int          start_errors;
    logic [31:0] addrs [4];
    logic [63:0] datas [4];
    logic [1:0]  rids [4];
    start_errors = error_count;
    data_gnt_i   = 1'b1;
    // one load per cycle into the lowest free slot
    for (int i = 0; i < 4; i++) begin
      addrs[i]      = $random(seed);
      addrs[i][2:0] = 3'd0;
      datas[i]      = {$random(seed), $random(seed)};
      valid_i       = 1'b1;
      trans_id_i    = 3'(i + 1);
      vaddr_i       = addrs[i];
      op_i          = op_list[i];
      @(negedge clk_i);
      check_value(name, 64'd1, 64'(pop_o));
      check_value(name, 64'(i), 64'(data_id_o));
      if (i > 0) begin
        check_value(name, 64'd1, 64'(tag_valid_o));
        check_value(name, 64'(addrs[i-1][31:12]), 64'(address_tag_o));
      end
      rids[i] = data_id_o;
      @(posedge clk_i);
      #1;
    end
    valid_i    = 1'b0;
    data_gnt_i = 1'b0;
    @(negedge clk_i);
    check_value(name, 64'd1, 64'(tag_valid_o));
    check_value(name, 64'(addrs[3][31:12]), 64'(address_tag_o));
    @(posedge clk_i);
    #1;
    for (int i = 3; i >= 0; i--) begin
      respond(name, rids[i], datas[i], 1'b1, 3'(i + 1),
              expected_load(datas[i], 3'd0, op_list[i]));
    end
    end_test(name, start_errors);
  endtask

  task automatic late_grant();
    string       name = "late_grant";
    int          start_errors;
    logic [31:0] addr;
    logic [63:0] data;
    logic [1:0]  rid;
    start_errors = error_count;
    addr         = $random(seed);
    addr[2:0]    = 3'd4;
    data         = {$random(seed), $random(seed)};
    issue_load(name, 3'd6, addr, LW, 3, rid);
    respond(name, rid, data, 1'b1, 3'd6, expected_load(data, 3'd4, LW));
    end_test(name, start_errors);
  endtask

  task automatic offset_stall();
    string       name = "offset_stall";
    int          start_errors;
    logic [31:0] addr;
    logic [63:0] data;
    logic [1:0]  rid;
    start_errors          = error_count;
    addr                  = $random(seed);
    addr[2:0]             = 3'd6;
    data                  = {$random(seed), $random(seed)};
    valid_i               = 1'b1;
    trans_id_i            = 3'd5;
    vaddr_i               = addr;
    op_i                  = LH;
    page_offset_matches_i = 1'b1;
    data_gnt_i            = 1'b1;
    // nothing may go out while a pending store overlaps
    repeat (4) begin
      @(negedge clk_i);
      check_value(name, 64'(addr[11:0]), 64'(page_offset_o));
      check_value(name, 64'd0, 64'(data_req_o));
      check_value(name, 64'd0, 64'(pop_o));
      @(posedge clk_i);
      #1;
    end
    page_offset_matches_i = 1'b0;
    issue_load(name, 3'd5, addr, LH, 0, rid);
    respond(name, rid, data, 1'b1, 3'd5, expected_load(data, 3'd6, LH));
    end_test(name, start_errors);
  endtask

  task automatic flush_inflight();
    string       name = "flush_inflight";
    int          start_errors;
    logic [31:0] addr;
    logic [63:0] data;
    logic [1:0]  rid0;
    logic [1:0]  rid1;
    logic [1:0]  rid2;
    start_errors = error_count;
    addr         = $random(seed);
    addr[2:0]    = 3'd0;
    data         = {$random(seed), $random(seed)};
    issue_load(name, 3'd1, addr, LD, rand_delay(), rid0);
    issue_load(name, 3'd2, addr + 32'd8, LD, rand_delay(), rid1);
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    // single kill cycle right after the flush
    @(negedge clk_i);
    check_value(name, 64'd1, 64'(kill_req_o));
    check_value(name, 64'd1, 64'(tag_valid_o));
    @(posedge clk_i);
    #1;
    @(negedge clk_i);
    check_value(name, 64'd0, 64'(kill_req_o));
    @(posedge clk_i);
    #1;
    // stale responses still come back but must stay silent
    respond(name, rid1, data, 1'b0, 3'd2, data);
    respond(name, rid0, ~data, 1'b0, 3'd1, ~data);
    issue_load(name, 3'd3, addr + 32'd3, LBU, rand_delay(), rid2);
    respond(name, rid2, data, 1'b1, 3'd3, expected_load(data, 3'd3, LBU));
    end_test(name, start_errors);
  endtask

  task automatic full_buffer();
    string       name = "full_buffer";
    int          start_errors;
    logic [31:0] addrs [5];
    logic [63:0] datas [5];
    logic [1:0]  rids [5];
    start_errors = error_count;
    for (int i = 0; i < 5; i++) begin
      addrs[i]      = $random(seed);
      addrs[i][2:0] = 3'd0;
      datas[i]      = {$random(seed), $random(seed)};
    end
    // an empty buffer fills from slot 0 upward
    for (int i = 0; i < 4; i++) begin
      issue_load(name, 3'(i), addrs[i], LD, rand_delay(), rids[i]);
      check_value(name, 64'(i), 64'(rids[i]));
    end
    // fifth load waits while every slot is taken
    valid_i    = 1'b1;
    trans_id_i = 3'd4;
    vaddr_i    = addrs[4];
    op_i       = LD;
    data_gnt_i = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_value(name, 64'd0, 64'(data_req_o));
      check_value(name, 64'd0, 64'(pop_o));
      @(posedge clk_i);
      #1;
    end
    respond(name, rids[1], datas[1], 1'b1, 3'd1, datas[1]);
    // slot 1 is now the only free one
    issue_load(name, 3'd4, addrs[4], LD, 0, rids[4]);
    check_value(name, 64'd1, 64'(rids[4]));
    respond(name, rids[4], datas[4], 1'b1, 3'd4, datas[4]);
    respond(name, rids[0], datas[0], 1'b1, 3'd0, datas[0]);
    respond(name, rids[2], datas[2], 1'b1, 3'd2, datas[2]);
    respond(name, rids[3], datas[3], 1'b1, 3'd3, datas[3]);
    end_test(name, start_errors);
  endtask

  //--------------------------------------
  // main sequence and watchdog
  //--------------------------------------
  initial begin
    clk_i                 = 1'b0;
    rst_n_i               = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    trans_id_i            = '0;
    vaddr_i               = '0;
    op_i                  = LD;
    page_offset_matches_i = 1'b0;
    data_gnt_i            = 1'b0;
    data_rvalid_i         = 1'b0;
    data_rid_i            = '0;
    data_rdata_i          = '0;
    repeat (reset_cycles - 1) @(posedge clk_i);
    // control outputs are quiet out of reset
    @(negedge clk_i);
    check_value("reset", 64'd0, 64'({pop_o, data_req_o, tag_valid_o, kill_req_o, valid_o}));
    @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    all_load_types();
    reverse_responses();
    late_grant();
    offset_stall();
    flush_inflight();
    full_buffer();
    $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #((num_tests * cycles_per_test + reset_cycles) * clk_period);
    $display("watchdog expired, the tests did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
logic/load_pkg.sv
logic/load_request_fsm.sv
logic/load_buffer.sv
logic/load_align.sv
logic/load_unit_top.sv
bench/load_unit_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := load_unit_tb
FILELIST   := all.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
